/* project.f */
+incdir+rtl
rtl/pcs_rx_pkg.sv
rtl/rx_descrambler.sv
rtl/rx_block_classifier.sv
rtl/rx_decoder_fsm.sv
rtl/rx_status_regs.sv
rtl/pcs_rx_top.sv
bench/pcs_rx_tb.sv

/* run.sh */
#!/bin/sh
# Builds the PCS receive testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module pcs_rx_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/Vpcs_rx_tb)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "TEST OK"; then
	exit 0
fi
echo "Pass message not found in the simulation output"
exit 1

/* bench/pcs_rx_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pcs_rx_macros.svh"

module pcs_rx_tb;

logic                    clock;
logic                    i_reset;
logic                    i_rx_valid;
pcs_rx_pkg::pcs_block_t  i_rx_block;
pcs_rx_pkg::xgmii_word_t o_rx_word;
logic                    o_rx_word_valid;
logic                    i_wb_cyc;
logic                    i_wb_stb;
logic                    i_wb_we;
logic [3:0]              i_wb_adr;
logic [31:0]             i_wb_dat;
logic [31:0]             o_wb_dat;
logic                    o_wb_ack;

logic [15:0]             lfsr_state = 16'd53;
logic [57:0]             scr_model;     // Last 58 scrambled bits sent with the newest in bit 57.
pcs_rx_pkg::rx_state_t   model_state;
pcs_rx_pkg::r_type_t     pend_type[$];  // Blocks sent but not yet decoded.
pcs_rx_pkg::xgmii_word_t pend_word[$];
pcs_rx_pkg::xgmii_word_t expect_q[$];
pcs_rx_pkg::xgmii_word_t want_word;
int                      exp_err;
int                      exp_frm;
int                      sent_count;
int                      cycle_count;
int                      error_count;
int                      test_start_errors;
int                      tests_passed;
int                      tests_failed;
logic [31:0]             read_value;

pcs_rx_top dut_i
(
	.clock           (clock),
	.i_reset         (i_reset),
	.i_rx_valid      (i_rx_valid),
	.i_rx_block      (i_rx_block),
	.o_rx_word       (o_rx_word),
	.o_rx_word_valid (o_rx_word_valid),
	.i_wb_cyc        (i_wb_cyc),
	.i_wb_stb        (i_wb_stb),
	.i_wb_we         (i_wb_we),
	.i_wb_adr        (i_wb_adr),
	.i_wb_dat        (i_wb_dat),
	.o_wb_dat        (o_wb_dat),
	.o_wb_ack        (o_wb_ack)
);

initial
begin
	clock = 1'b0;
	forever #5 clock = ~clock;
end

// Taps 16, 14, 13 and 11.
function automatic logic next_bit();
	logic feedback;
	feedback = lfsr_state[0] ^ lfsr_state[2] ^ lfsr_state[3] ^ lfsr_state[5];
	lfsr_state = {feedback, lfsr_state[15:1]};
	return feedback;
endfunction

function automatic logic [63:0] random_bits(input int count);
	logic [63:0] value;
	value = '0;
	for (int i = 0; i < count; i++)
		value = {value[62:0], next_bit()};
	return value;
endfunction

// Transmit scrambler 1 + x^39 + x^58 that sends bit 0 first.
function automatic logic [63:0] scramble(input logic [63:0] plain);
	logic [121:0] line;
	line = {64'h0, scr_model};
	for (int i = 0; i < 64; i++)
		line[58 + i] = plain[i] ^ line[i + 19] ^ line[i];
	scr_model = line[121:64];
	return line[121:58];
endfunction

function automatic logic [7:0] term_type(input int n);
	case (n)
		0: return `PCS_BT_T0;
		1: return `PCS_BT_T1;
		2: return `PCS_BT_T2;
		3: return `PCS_BT_T3;
		4: return `PCS_BT_T4;
		5: return `PCS_BT_T5;
		6: return `PCS_BT_T6;
		default: return `PCS_BT_T7;
	endcase
endfunction

function automatic logic [31:0] expected_count(input int count);
	return (count > 65535) ? 32'd65535 : 32'(count);
endfunction

task automatic report_mismatch(input string name, input logic [63:0] got, input logic [63:0] want);
	$display("CHECK FAILED %s: got 0x%h expected 0x%h", name, got, want);
	error_count++;
endtask

task automatic finish_test(input string name);
	if (error_count == test_start_errors)
	begin
		tests_passed++;
		$display("Test %s: passed", name);
	end
	else
	begin
		tests_failed++;
		$display("Test %s: failed with %0d errors", name, error_count - test_start_errors);
	end
	test_start_errors = error_count;
endtask

// Runs the receive state machine on the oldest pending block once its successor is known.
task automatic model_step();
	pcs_rx_pkg::r_type_t     curr;
	pcs_rx_pkg::r_type_t     following;
	pcs_rx_pkg::rx_state_t   target;
	pcs_rx_pkg::xgmii_word_t word;
	logic                    next_ok;
	curr = pend_type.pop_front();
	word = pend_word.pop_front();
	following = pend_type[0];
	next_ok = (following == pcs_rx_pkg::R_S) || (following == pcs_rx_pkg::R_C);
	target = pcs_rx_pkg::RX_E;
	case (model_state)
		pcs_rx_pkg::RX_D:
		begin
			if (curr == pcs_rx_pkg::R_D)
				target = pcs_rx_pkg::RX_D;
			else if (curr == pcs_rx_pkg::R_T && next_ok)
				target = pcs_rx_pkg::RX_T;
		end
		pcs_rx_pkg::RX_E:
		begin
			if (curr == pcs_rx_pkg::R_C)
				target = pcs_rx_pkg::RX_C;
			else if (curr == pcs_rx_pkg::R_S || curr == pcs_rx_pkg::R_D)
				target = pcs_rx_pkg::RX_D;
			else if (curr == pcs_rx_pkg::R_T && next_ok)
				target = pcs_rx_pkg::RX_T;
		end
		default:
		begin
			if (curr == pcs_rx_pkg::R_C)
				target = pcs_rx_pkg::RX_C;
			else if (curr == pcs_rx_pkg::R_S)
				target = pcs_rx_pkg::RX_D;
		end
	endcase
	model_state = target;
	if (target == pcs_rx_pkg::RX_E)
	begin
		word.data = `PCS_EBLOCK_DATA;
		word.ctrl = `PCS_EBLOCK_CTRL;
		exp_err++;
	end
	else if (target == pcs_rx_pkg::RX_T)
		exp_frm++;
	expect_q.push_back(word);
endtask

task automatic drive_block(input logic [1:0] sync, input logic [63:0] payload,
		input pcs_rx_pkg::r_type_t r_type, input pcs_rx_pkg::xgmii_word_t word);
	int          gap;
	logic [63:0] scrambled;
	gap = int'(random_bits(2));
	@(posedge clock);
	scrambled = scramble(payload);
	i_rx_valid <= 1'b1;
	i_rx_block.sync <= sync;
	i_rx_block.payload <= scrambled;
	sent_count++;
	pend_type.push_back(r_type);
	pend_word.push_back(word);
	if (pend_type.size() == 4)
		model_step();  // Block n leaves the DUT when block n+3 goes in.
	repeat (gap)
	begin
		@(posedge clock);
		i_rx_valid <= 1'b0;
	end
endtask

task automatic idle_block();
	logic [63:0]             payload;
	pcs_rx_pkg::xgmii_word_t word;
	payload = {56'h0, `PCS_BT_IDLE};
	word.data = '0;
	word.ctrl = 8'hFF;
	for (int i = 0; i < 8; i++)
	begin
		if (random_bits(2) == 64'd3)
		begin
			payload[8 + 7 * i +: 7] = 7'h1E;  // An error code now and then.
			word.data[8 * i +: 8] = `PCS_XGMII_ERROR;
		end
		else
			word.data[8 * i +: 8] = `PCS_XGMII_IDLE;
	end
	drive_block(2'b10, payload, pcs_rx_pkg::R_C, word);
endtask

task automatic start_block();
	logic [63:0]             payload;
	pcs_rx_pkg::xgmii_word_t word;
	payload = random_bits(64);
	payload[7:0] = `PCS_BT_START;
	word.data = {payload[63:8], `PCS_XGMII_START};
	word.ctrl = 8'h01;
	drive_block(2'b10, payload, pcs_rx_pkg::R_S, word);
endtask

task automatic data_block();
	logic [63:0]             payload;
	pcs_rx_pkg::xgmii_word_t word;
	payload = random_bits(64);
	word.data = payload;
	word.ctrl = 8'h00;
	drive_block(2'b01, payload, pcs_rx_pkg::R_D, word);
endtask

task automatic term_block(input int n);
	logic [63:0]             payload;
	logic [63:0]             tail;
	pcs_rx_pkg::xgmii_word_t word;
	payload = random_bits(8 * n) << 8;
	payload[7:0] = term_type(n);
	tail = payload >> 8;
	word.ctrl = '0;
	for (int i = 0; i < 8; i++)
	begin
		if (i < n)
			word.data[8 * i +: 8] = tail[8 * i +: 8];
		else
		begin
			word.data[8 * i +: 8] = (i == n) ? `PCS_XGMII_TERM : `PCS_XGMII_IDLE;
			word.ctrl[i] = 1'b1;
		end
	end
	drive_block(2'b10, payload, pcs_rx_pkg::R_T, word);
endtask

// The kind picks sync 00, sync 11, an unknown type or an idle block with a bad code.
task automatic bad_block(input int kind);
	logic [63:0] payload;
	logic [1:0]  sync;
	payload = random_bits(64);
	sync = 2'b10;
	if (kind == 0)
		sync = 2'b00;
	else if (kind == 1)
		sync = 2'b11;
	else if (kind == 2)
		payload[7:0] = 8'h2D;
	else
	begin
		payload = {56'h0, `PCS_BT_IDLE};
		payload[29:23] = 7'h55;
	end
	drive_block(sync, payload, pcs_rx_pkg::R_E, '0);
endtask

task automatic drain_pipeline();
	repeat (3) idle_block();  // Pushes the last real block past the lookahead.
	@(posedge clock);
	i_rx_valid <= 1'b0;
	while (expect_q.size() != 0)
		@(negedge clock);
	repeat (3) @(posedge clock);
endtask

task automatic access_reg(input logic we, input logic [3:0] adr, input logic [31:0] wdata,
		output logic [31:0] rdata);
	int waited;
	waited = 0;
	@(posedge clock);
	i_wb_cyc <= 1'b1;
	i_wb_stb <= 1'b1;
	i_wb_we <= we;
	i_wb_adr <= adr;
	i_wb_dat <= wdata;
	@(negedge clock);
	while (o_wb_ack !== 1'b1)
	begin
		waited++;
		@(negedge clock);
	end
	rdata = o_wb_dat;
	if (waited != 1)
	begin
		$display("Wishbone ack came %0d cycles after the request instead of 1", waited);
		error_count++;
	end
	@(posedge clock);
	i_wb_cyc <= 1'b0;
	i_wb_stb <= 1'b0;
	i_wb_we <= 1'b0;
endtask

// Compares every valid output word with the model in order.
always @(negedge clock)
begin
	if (o_rx_word_valid === 1'b1)
	begin
		if (expect_q.size() == 0)
		begin
			$display("Output word 0x%h arrived with no expected word left", o_rx_word);
			error_count++;
		end
		else
		begin
			want_word = expect_q.pop_front();
			if (o_rx_word.data !== want_word.data)
				report_mismatch("o_rx_word.data", o_rx_word.data, want_word.data);
			if (o_rx_word.ctrl !== want_word.ctrl)
				report_mismatch("o_rx_word.ctrl", 64'(o_rx_word.ctrl), 64'(want_word.ctrl));
		end
	end
end

initial
begin
	cycle_count = 0;
	while (cycle_count < 4 * sent_count + 200)
	begin
		@(posedge clock);
		cycle_count++;
	end
	$display("Timeout after %0d cycles, the DUT stopped producing words or acks", cycle_count);
	$display("TEST FAILED");
	$finish;
end

initial
begin
	i_reset = 1'b1;
	i_rx_valid = 1'b0;
	i_rx_block = '0;
	i_wb_cyc = 1'b0;
	i_wb_stb = 1'b0;
	i_wb_we = 1'b0;
	i_wb_adr = '0;
	i_wb_dat = '0;
	scr_model = '0;
	model_state = pcs_rx_pkg::RX_INIT;
	exp_err = 0;
	exp_frm = 0;
	sent_count = 0;
	error_count = 0;
	test_start_errors = 0;
	tests_passed = 0;
	tests_failed = 0;
	repeat (5) @(posedge clock);
	i_reset <= 1'b0;

	@(negedge clock);
	if (o_rx_word_valid !== 1'b0)
		report_mismatch("o_rx_word_valid", 64'(o_rx_word_valid), 64'h0);
	if (o_rx_word.data !== `PCS_LBLOCK_DATA)
		report_mismatch("o_rx_word.data", o_rx_word.data, `PCS_LBLOCK_DATA);
	if (o_rx_word.ctrl !== `PCS_LBLOCK_CTRL)
		report_mismatch("o_rx_word.ctrl", 64'(o_rx_word.ctrl), 64'(`PCS_LBLOCK_CTRL));
	if (o_wb_ack !== 1'b0)
		report_mismatch("o_wb_ack", 64'(o_wb_ack), 64'h0);
	finish_test("reset state");

	for (int f = 0; f < 16; f++)
	begin
		repeat (int'(random_bits(2))) idle_block();
		start_block();
		repeat (int'(random_bits(3))) data_block();
		term_block(int'(random_bits(3)));
	end
	drain_pipeline();
	finish_test("well-formed traffic");

	for (int r = 0; r < 2; r++)
	begin
		idle_block();
		data_block();  // Data without a start.
		data_block();
		idle_block();
		start_block();
		data_block();
		start_block();  // Start inside a frame.
		data_block();
		term_block(int'(random_bits(3)));
		idle_block();
		start_block();
		term_block(int'(random_bits(3)));
		data_block();  // Terminate followed by data.
		idle_block();
		idle_block();
		for (int k = 0; k < 4; k++)
		begin
			bad_block(k);
			idle_block();
		end
		start_block();
		data_block();
		bad_block(int'(random_bits(2)));
		data_block();
		term_block(int'(random_bits(3)));
		idle_block();
	end
	drain_pipeline();
	finish_test("illegal block order");

	access_reg(1'b0, `PCS_REG_ERR, 32'h0, read_value);
	if (read_value !== expected_count(exp_err))
		report_mismatch("o_wb_dat at PCS_REG_ERR", 64'(read_value),
			64'(expected_count(exp_err)));
	access_reg(1'b0, `PCS_REG_FRM, 32'h0, read_value);
	if (read_value !== expected_count(exp_frm))
		report_mismatch("o_wb_dat at PCS_REG_FRM", 64'(read_value),
			64'(expected_count(exp_frm)));
	finish_test("counter reads");

	access_reg(1'b1, `PCS_REG_ERR, 32'h0, read_value);
	exp_err = 0;
	exp_frm = 0;
	access_reg(1'b0, `PCS_REG_ERR, 32'h0, read_value);
	if (read_value !== expected_count(exp_err))
		report_mismatch("o_wb_dat at PCS_REG_ERR", 64'(read_value),
			64'(expected_count(exp_err)));
	access_reg(1'b0, `PCS_REG_FRM, 32'h0, read_value);
	if (read_value !== expected_count(exp_frm))
		report_mismatch("o_wb_dat at PCS_REG_FRM", 64'(read_value),
			64'(expected_count(exp_frm)));
	access_reg(1'b0, 4'h8, 32'h0, read_value);
	if (read_value !== 32'h0)
		report_mismatch("o_wb_dat at unknown address", 64'(read_value), 64'h0);
	finish_test("counter clear");

	$display("Tests passed: %0d, tests failed: %0d, failed checks: %0d", tests_passed,
		tests_failed, error_count);
	if (error_count == 0)
		$display("TEST OK");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

`default_nettype wire

/* rtl/pcs_rx_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pcs_rx_top
(
	input  wire                          clock,
	input  wire                          i_reset,
	input  wire                          i_rx_valid,
	input  wire pcs_rx_pkg::pcs_block_t  i_rx_block,
	output pcs_rx_pkg::xgmii_word_t      o_rx_word,
	output logic                         o_rx_word_valid,
	input  wire                          i_wb_cyc,
	input  wire                          i_wb_stb,
	input  wire                          i_wb_we,
	input  wire  [3:0]                   i_wb_adr,
	input  wire  [31:0]                  i_wb_dat,
	output logic [31:0]                  o_wb_dat,
	output logic                         o_wb_ack
);

pcs_rx_pkg::pcs_block_t  plain_block;
logic                    plain_valid;
pcs_rx_pkg::classified_t curr;
pcs_rx_pkg::r_type_t     r_type_next;
logic                    curr_valid;
logic                    err_event;
logic                    frame_event;

rx_descrambler descrambler_i
(
	.clock   (clock),
	.i_reset (i_reset),
	.i_valid (i_rx_valid),
	.i_block (i_rx_block),
	.o_valid (plain_valid),
	.o_block (plain_block)
);

rx_block_classifier classifier_i
(
	.clock         (clock),
	.i_reset       (i_reset),
	.i_valid       (plain_valid),
	.i_block       (plain_block),
	.o_valid       (curr_valid),
	.o_curr        (curr),
	.o_r_type_next (r_type_next)
);

rx_decoder_fsm decoder_i
(
	.clock           (clock),
	.i_reset         (i_reset),
	.i_valid         (curr_valid),
	.i_curr          (curr),
	.i_r_type_next   (r_type_next),
	.o_rx_word       (o_rx_word),
	.o_rx_word_valid (o_rx_word_valid),
	.o_err_event     (err_event),
	.o_frame_event   (frame_event)
);

rx_status_regs status_i
(
	.clock         (clock),
	.i_reset       (i_reset),
	.i_err_event   (err_event),
	.i_frame_event (frame_event),
	.i_wb_cyc      (i_wb_cyc),
	.i_wb_stb      (i_wb_stb),
	.i_wb_we       (i_wb_we),
	.i_wb_adr      (i_wb_adr),
	.i_wb_dat      (i_wb_dat),
	.o_wb_dat      (o_wb_dat),
	.o_wb_ack      (o_wb_ack)
);

endmodule

`default_nettype wire

/* rtl/rx_status_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pcs_rx_macros.svh"

module rx_status_regs
(
	input  wire         clock,
	input  wire         i_reset,
	input  wire         i_err_event,
	input  wire         i_frame_event,
	input  wire         i_wb_cyc,
	input  wire         i_wb_stb,
	input  wire         i_wb_we,
	input  wire  [3:0]  i_wb_adr,
	input  wire  [31:0] i_wb_dat,
	output logic [31:0] o_wb_dat,
	output logic        o_wb_ack
);

logic [`PCS_CNT_W-1:0] err_count;
logic [`PCS_CNT_W-1:0] frame_count;
logic [31:0]           read_data;
logic                  access;  // First cycle of a bus request.
logic                  clear;

// Saturating count step, a clear wins over an event.
function automatic logic [`PCS_CNT_W-1:0] count_step(input logic [`PCS_CNT_W-1:0] count,
		input logic event_hit, input logic clr);
	if (clr)
		return '0;
	else if (event_hit && count != '1)
		return count + 1'b1;
	else
		return count;
endfunction

assign access = i_wb_cyc & i_wb_stb & ~o_wb_ack;
assign clear = access & i_wb_we & (i_wb_adr == `PCS_REG_ERR);

always_comb
begin
	read_data = '0;  // unknown addresses
	case (i_wb_adr)
		`PCS_REG_ERR: read_data = {{(32 - `PCS_CNT_W){1'b0}}, err_count};
		`PCS_REG_FRM: read_data = {{(32 - `PCS_CNT_W){1'b0}}, frame_count};
		default: read_data = '0;
	endcase
end

always_ff @(posedge clock or posedge i_reset)
begin
	if (i_reset)
	begin
		err_count <= '0;
		frame_count <= '0;
		o_wb_ack <= 1'b0;
	end
	else
	begin
		o_wb_ack <= access;
		err_count <= count_step(err_count, i_err_event, clear);
		frame_count <= count_step(frame_count, i_frame_event, clear);
	end
end

always_ff @(posedge clock)
begin
	if (access)
		o_wb_dat <= i_wb_we ? i_wb_dat : read_data;  // Writes echo the bus data.
end

endmodule

`default_nettype wire

/* rtl/rx_decoder_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pcs_rx_macros.svh"

module rx_decoder_fsm
(
	input  wire                           clock,
	input  wire                           i_reset,
	input  wire                           i_valid,
	input  wire pcs_rx_pkg::classified_t  i_curr,
	input  wire pcs_rx_pkg::r_type_t      i_r_type_next,
	output pcs_rx_pkg::xgmii_word_t       o_rx_word,
	output logic                          o_rx_word_valid,
	output logic                          o_err_event,
	output logic                          o_frame_event
);

pcs_rx_pkg::rx_state_t state;
pcs_rx_pkg::rx_state_t state_next;
pcs_rx_pkg::r_type_t   r_type;
logic                  next_ok;  // The block after a terminate may start a new run.

assign r_type = i_curr.r_type;
assign next_ok = (i_r_type_next == pcs_rx_pkg::R_S) || (i_r_type_next == pcs_rx_pkg::R_C);

always_comb
begin
	state_next = pcs_rx_pkg::RX_E;
	case (state)
		pcs_rx_pkg::RX_INIT, pcs_rx_pkg::RX_C, pcs_rx_pkg::RX_T:
		begin
			if (r_type == pcs_rx_pkg::R_C)
				state_next = pcs_rx_pkg::RX_C;
			else if (r_type == pcs_rx_pkg::R_S)
				state_next = pcs_rx_pkg::RX_D;
		end
		pcs_rx_pkg::RX_D:
		begin
			if (r_type == pcs_rx_pkg::R_D)
				state_next = pcs_rx_pkg::RX_D;
			else if (r_type == pcs_rx_pkg::R_T && next_ok)
				state_next = pcs_rx_pkg::RX_T;
		end
		pcs_rx_pkg::RX_E:
		begin
			if (r_type == pcs_rx_pkg::R_C)
				state_next = pcs_rx_pkg::RX_C;
			else if (r_type == pcs_rx_pkg::R_S || r_type == pcs_rx_pkg::R_D)
				state_next = pcs_rx_pkg::RX_D;
			else if (r_type == pcs_rx_pkg::R_T && next_ok)
				state_next = pcs_rx_pkg::RX_T;
		end
		default: state_next = pcs_rx_pkg::RX_E;
	endcase
end

always_ff @(posedge clock or posedge i_reset)
begin
	if (i_reset)
	begin
		state <= pcs_rx_pkg::RX_INIT;
		o_rx_word.data <= `PCS_LBLOCK_DATA;  // Local fault until the first block.
		o_rx_word.ctrl <= `PCS_LBLOCK_CTRL;
		o_rx_word_valid <= 1'b0;
		o_err_event <= 1'b0;
		o_frame_event <= 1'b0;
	end
	else
	begin
		o_rx_word_valid <= i_valid;
		// Every block decoded in RX_E counts, a repeated error too.
		o_err_event <= i_valid && (state_next == pcs_rx_pkg::RX_E);
		o_frame_event <= i_valid && (state_next == pcs_rx_pkg::RX_T);
		if (i_valid)
		begin
			state <= state_next;
			if (state_next == pcs_rx_pkg::RX_E)
			begin
				o_rx_word.data <= `PCS_EBLOCK_DATA;
				o_rx_word.ctrl <= `PCS_EBLOCK_CTRL;
			end
			else
				o_rx_word <= i_curr.word;
		end
	end
end

endmodule

`default_nettype wire

/* rtl/rx_block_classifier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pcs_rx_macros.svh"

module rx_block_classifier
(
	input  wire                          clock,
	input  wire                          i_reset,
	input  wire                          i_valid,
	input  wire pcs_rx_pkg::pcs_block_t  i_block,
	output logic                         o_valid,
	output pcs_rx_pkg::classified_t      o_curr,
	output pcs_rx_pkg::r_type_t          o_r_type_next
);

localparam [1:0] SYNC_DATA = 2'b01;
localparam [1:0] SYNC_CTRL = 2'b10;
localparam [6:0] CODE_IDLE = 7'h00;
localparam [6:0] CODE_ERROR = 7'h1E;

logic [7:0]              block_type;
logic [63:0]             tail;        // Payload bytes after the type field.
logic [63:0]             idle_data;
logic                    codes_ok;
logic                    is_term;
logic [2:0]              term_len;
logic [63:0]             term_data;
logic [7:0]              term_ctrl;
pcs_rx_pkg::classified_t cls;
pcs_rx_pkg::classified_t slot;        // Lookahead block.
logic                    slot_full;
logic                    curr_full;

assign block_type = i_block.payload[7:0];
assign tail = {8'h00, i_block.payload[63:8]};

// Eight 7-bit control codes follow the type byte.
always_comb
begin
	codes_ok = 1'b1;
	idle_data = '0;
	for (int i = 0; i < 8; i++)
	begin
		if (i_block.payload[8 + 7 * i +: 7] == CODE_IDLE)
			idle_data[8 * i +: 8] = `PCS_XGMII_IDLE;
		else if (i_block.payload[8 + 7 * i +: 7] == CODE_ERROR)
			idle_data[8 * i +: 8] = `PCS_XGMII_ERROR;
		else
			codes_ok = 1'b0;
	end
end

always_comb
begin
	is_term = 1'b1;
	term_len = 3'd0;
	case (block_type)
		`PCS_BT_T0: term_len = 3'd0;
		`PCS_BT_T1: term_len = 3'd1;
		`PCS_BT_T2: term_len = 3'd2;
		`PCS_BT_T3: term_len = 3'd3;
		`PCS_BT_T4: term_len = 3'd4;
		`PCS_BT_T5: term_len = 3'd5;
		`PCS_BT_T6: term_len = 3'd6;
		`PCS_BT_T7: term_len = 3'd7;
		default: is_term = 1'b0;
	endcase
end

// Data lanes, then the terminate character, then idles up to lane 7.
always_comb
begin
	term_data = '0;
	term_ctrl = '0;
	for (int i = 0; i < 8; i++)
	begin
		if (i < int'(term_len))
			term_data[8 * i +: 8] = tail[8 * i +: 8];
		else if (i == int'(term_len))
		begin
			term_data[8 * i +: 8] = `PCS_XGMII_TERM;
			term_ctrl[i] = 1'b1;
		end
		else
		begin
			term_data[8 * i +: 8] = `PCS_XGMII_IDLE;
			term_ctrl[i] = 1'b1;
		end
	end
end

always_comb
begin
	cls = '0;
	cls.r_type = pcs_rx_pkg::R_E;
	if (i_block.sync == SYNC_DATA)
	begin
		cls.r_type = pcs_rx_pkg::R_D;
		cls.word.data = i_block.payload;
	end
	else if (i_block.sync == SYNC_CTRL)
	begin
		if (block_type == `PCS_BT_IDLE && codes_ok)
		begin
			cls.r_type = pcs_rx_pkg::R_C;
			cls.word.data = idle_data;
			cls.word.ctrl = 8'hFF;
		end
		else if (block_type == `PCS_BT_START)
		begin
			cls.r_type = pcs_rx_pkg::R_S;
			cls.word.data = {i_block.payload[63:8], `PCS_XGMII_START};
			cls.word.ctrl = 8'h01;
		end
		else if (is_term)
		begin
			cls.r_type = pcs_rx_pkg::R_T;
			cls.word.data = term_data;
			cls.word.ctrl = term_ctrl;
		end
	end
end

always_ff @(posedge clock or posedge i_reset)
begin
	if (i_reset)
	begin
		slot_full <= 1'b0;
		curr_full <= 1'b0;
	end
	else if (i_valid)
	begin
		slot_full <= 1'b1;
		curr_full <= slot_full;
	end
end

always_ff @(posedge clock)
begin
	if (i_valid)
	begin
		slot <= cls;
		o_curr <= slot;
	end
end

assign o_r_type_next = slot.r_type;  // The slot always holds the block after o_curr.
assign o_valid = i_valid & curr_full;

endmodule

`default_nettype wire

/* rtl/rx_descrambler.sv */
`timescale 1ns/1ps
`default_nettype none

module rx_descrambler
(
	input  wire                          clock,
	input  wire                          i_reset,
	input  wire                          i_valid,
	input  wire pcs_rx_pkg::pcs_block_t  i_block,
	output logic                         o_valid,
	output pcs_rx_pkg::pcs_block_t       o_block
);

logic [57:0]  scr_state;  // Last 58 scrambled bits, the newest in bit 57.
logic [121:0] history;
logic [63:0]  plain;
logic         primed;     // Set once o_block holds a block.

// Bit i of the payload sits at history[58+i], so taps 39 and 58 land at i+19 and i.
assign history = {i_block.payload, scr_state};

always_comb
begin
	for (int i = 0; i < 64; i++)
		plain[i] = i_block.payload[i] ^ history[i + 19] ^ history[i];
end

always_ff @(posedge clock or posedge i_reset)
begin
	if (i_reset)
	begin
		scr_state <= '0;
		primed <= 1'b0;
	end
	else if (i_valid)
	begin
		scr_state <= i_block.payload[63:6];  // The descrambler is fed with received bits.
		primed <= 1'b1;
	end
end

always_ff @(posedge clock)
begin
	if (i_valid)
	begin
		o_block.sync <= i_block.sync;
		o_block.payload <= plain;
	end
end

// The held block moves on together with the next one coming in.
assign o_valid = i_valid & primed;

endmodule

`default_nettype wire

/* rtl/pcs_rx_pkg.sv */
`default_nettype none

package pcs_rx_pkg;

// One 66-bit block as delivered by the gearbox.
typedef struct packed
{
	logic [1:0]  sync;     // 01 is a data block, 10 a control block.
	logic [63:0] payload;  // Bit 0 is received first.
} pcs_block_t;

// XGMII word, lane 0 sits in data[7:0] and ctrl[0].
typedef struct packed
{
	logic [63:0] data;
	logic [7:0]  ctrl;
} xgmii_word_t;

// Block classes used by the receive state machine.
typedef enum logic [2:0]
{
	R_D,
	R_S,
	R_C,
	R_T,
	R_E
} r_type_t;

typedef enum logic [2:0]
{
	RX_INIT,
	RX_C,
	RX_D,
	RX_T,
	RX_E
} rx_state_t;

// A decoded block together with its class.
typedef struct packed
{
	r_type_t     r_type;
	xgmii_word_t word;
} classified_t;

endpackage

`default_nettype wire

/* rtl/pcs_rx_macros.svh */
`ifndef PCS_RX_MACROS_SVH
`define PCS_RX_MACROS_SVH

`define PCS_XGMII_IDLE  8'h07
`define PCS_XGMII_ERROR 8'hFE
`define PCS_XGMII_START 8'hFB
`define PCS_XGMII_TERM  8'hFD

`define PCS_BT_IDLE  8'h1E
`define PCS_BT_START 8'h78
`define PCS_BT_T0    8'h87
`define PCS_BT_T1    8'h99
`define PCS_BT_T2    8'hAA
`define PCS_BT_T3    8'hB4
`define PCS_BT_T4    8'hCC
`define PCS_BT_T5    8'hD2
`define PCS_BT_T6    8'hE1
`define PCS_BT_T7    8'hFF

`define PCS_EBLOCK_DATA 64'hFEFEFEFE_FEFEFEFE
`define PCS_EBLOCK_CTRL 8'hFF
`define PCS_LBLOCK_DATA 64'h0100009C_0100009C
`define PCS_LBLOCK_CTRL 8'h11

`define PCS_CNT_W   16
`define PCS_REG_ERR 4'h0
`define PCS_REG_FRM 4'h4

`endif
